// File: common/psram_consts.svh
/* Counts assume a 48 MHz clk. Step numbers must match the tables in the two engines,
   and config register 0 is written for read latency 3 */
`ifndef PSRAM_CONSTS_SVH
`define PSRAM_CONSTS_SVH

// Power-up wait, 150 us
`define PSRAM_STARTUP_CYCLES 7200
// Recovery after soft reset, 400 ns
`define PSRAM_RESET_CYCLES 20
// Read wave step to registered pad input
`define PSRAM_RD_DELAY 3

// Command bytes
`define PSRAM_CMD_RSTEN 8'h66
`define PSRAM_CMD_RST 8'h99
`define PSRAM_CMD_WREN 8'h06
`define PSRAM_CMD_WRREG 8'h71
`define PSRAM_CMD_RDMEM 8'hEE
`define PSRAM_CMD_WRMEM 8'hDE

// Config register 0, latency 3
`define PSRAM_CR0_VALUE 16'h8FEF
`define PSRAM_CR0_ADDR 32'h0000_0004

// Chain lengths and table step numbers
`define PSRAM_RST_STEPS 3
`define PSRAM_CFG_STEPS 8
`define PSRAM_WR_STEPS 18
`define PSRAM_RD_STEPS 15
`define PSRAM_LAT_STEP 3
`define PSRAM_WREADY_STEP 8
`define PSRAM_DATA_STEP 10
`define PSRAM_WR_BEATS 8
`define PSRAM_RD_BEATS 4

`endif

// File: common/psram_pkg.sv
/* Phase fields run 0 to 3 from the left, and an external 4x serializer sends
   them to the pads in that order */
`default_nettype none

package psram_pkg;

	// One clk cycle of pad outputs, 4 phases each
	typedef struct packed {
		logic [0:3] sclk;
		logic [0:3] cs;
		logic [0:3] dq_oe;
		logic [0:3][7:0] dq;
		logic rwds_oe;
	} psram_pad_out_t;

	// Engine output, le marks a read data step
	typedef struct packed {
		psram_pad_out_t pad;
		logic le;
	} psram_wave_t;

	// Two captured bytes per step, first byte on top
	typedef struct packed {
		logic rwds0;
		logic [7:0] data0;
		logic rwds1;
		logic [7:0] data1;
	} psram_pad_in_t;

	typedef enum logic [1:0] {
		CMD_RESET,
		CMD_CONFIG,
		CMD_WRITE,
		CMD_READ
	} psram_cmd_e;

	typedef struct packed {
		psram_cmd_e cmd;
		logic [24:0] addr;
	} psram_req_t;

	// Active step with chip select and sclk 0110
	// First byte on phases 0 and 1, second on phases 2 and 3
	function automatic psram_pad_out_t psram_step(input logic oe, input logic [7:0] b0,
		input logic [7:0] b1);
		psram_pad_out_t p;
		p = '0;
		p.sclk = 4'b0110;
		p.cs = 4'b1111;
		p.dq_oe = {4{oe}};
		p.dq = {b0, b0, b1, b1};
		return p;
	endfunction

endpackage

`default_nettype wire

// File: engine/psram_write_engine.sv
/* Reset, config and memory write commands. No write back-pressure: wvalid must be
   high on every wready cycle, and a beat goes out two steps after acceptance */
`timescale 1ns/1ps
`default_nettype none

module psram_write_engine import psram_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire psram_req_t req_data,
	input wire logic [15:0] wdata,
	input wire logic wvalid,
	output logic ack,
	output logic wready,
	output psram_wave_t wave
);

`include "psram_consts.svh"

	localparam logic [31:0] CR0_ADDR = `PSRAM_CR0_ADDR;
	localparam logic [15:0] CR0_VAL = `PSRAM_CR0_VALUE;

	// One-hot step chains
	logic [0:`PSRAM_RST_STEPS-1] rst_sr;
	logic [0:`PSRAM_CFG_STEPS-1] cfg_sr;
	logic [0:`PSRAM_WR_STEPS-1] wr_sr;
	logic start;
	logic last_step;
	logic [31:0] wr_addr;
	logic [15:0] wd_q1;
	logic [15:0] wd_q2;
	psram_pad_out_t pad;

	// Idle means no step running and the previous ack released
	assign start = req && !ack && !(|rst_sr) && !(|cfg_sr) && !(|wr_sr);
	assign last_step = rst_sr[`PSRAM_RST_STEPS-1] || cfg_sr[`PSRAM_CFG_STEPS-1] ||
		wr_sr[`PSRAM_WR_STEPS-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			rst_sr <= '0;
			cfg_sr <= '0;
			wr_sr <= '0;
			ack <= 1'b0;
		end else begin
			rst_sr <= {start && (req_data.cmd == CMD_RESET), rst_sr[0:`PSRAM_RST_STEPS-2]};
			cfg_sr <= {start && (req_data.cmd == CMD_CONFIG), cfg_sr[0:`PSRAM_CFG_STEPS-2]};
			wr_sr <= {start && (req_data.cmd == CMD_WRITE), wr_sr[0:`PSRAM_WR_STEPS-2]};
			if (last_step)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Write data pacing
	////////////////////////////////////////////////////////////

	assign wready = |wr_sr[`PSRAM_WREADY_STEP +: `PSRAM_WR_BEATS];

	// Two-deep pipe, beat out on step s+2
	always_ff @(posedge clk) begin
		if (wready && wvalid)
			wd_q1 <= wdata;
		wd_q2 <= wd_q1;
	end

	// 16 byte aligned byte address
	assign wr_addr = {7'h00, req_data.addr[24:4], 4'h0};

	////////////////////////////////////////////////////////////
	// Step tables
	////////////////////////////////////////////////////////////

	always_comb begin
		pad = '0;
		// Reset enable, cs gap, reset
		if (rst_sr[0])
			pad |= psram_step(1'b1, `PSRAM_CMD_RSTEN, `PSRAM_CMD_RSTEN);
		if (rst_sr[2])
			pad |= psram_step(1'b1, `PSRAM_CMD_RST, `PSRAM_CMD_RST);
		// WREN, gap, register write, gap, WREN again
		if (cfg_sr[0] || cfg_sr[7])
			pad |= psram_step(1'b1, `PSRAM_CMD_WREN, `PSRAM_CMD_WREN);
		if (cfg_sr[2])
			pad |= psram_step(1'b1, `PSRAM_CMD_WRREG, `PSRAM_CMD_WRREG);
		if (cfg_sr[3])
			pad |= psram_step(1'b1, CR0_ADDR[31:24], CR0_ADDR[23:16]);
		if (cfg_sr[4])
			pad |= psram_step(1'b1, CR0_ADDR[15:8], CR0_ADDR[7:0]);
		if (cfg_sr[5])
			pad |= psram_step(1'b1, CR0_VAL[15:8], CR0_VAL[7:0]);
		// Memory write command and address
		if (wr_sr[0])
			pad |= psram_step(1'b1, `PSRAM_CMD_WRMEM, `PSRAM_CMD_WRMEM);
		if (wr_sr[1])
			pad |= psram_step(1'b1, wr_addr[31:24], wr_addr[23:16]);
		if (wr_sr[2])
			pad |= psram_step(1'b1, wr_addr[15:8], wr_addr[7:0]);
		// Latency, bus released
		for (int s = `PSRAM_LAT_STEP; s < `PSRAM_DATA_STEP; s++)
			if (wr_sr[s])
				pad |= psram_step(1'b0, 8'h00, 8'h00);
		// Data beats, high byte first, rwds driven as mask
		for (int s = `PSRAM_DATA_STEP; s < `PSRAM_WR_STEPS; s++)
			if (wr_sr[s]) begin
				pad |= psram_step(1'b1, wd_q2[15:8], wd_q2[7:0]);
				pad.rwds_oe = 1'b1;
			end
	end

	assign wave = '{pad: pad, le: 1'b0};

	// Master keeps data valid through the whole ready window
	a_wvalid_on_wready: assert property (@(posedge clk) disable iff (reset)
		wready |-> wvalid);

endmodule

`default_nettype wire

// File: engine/psram_read_engine.sv
/* Memory read of 8 bytes at an 8 byte aligned address, latency 3.
   le marks the 4 data steps; the phy lines them up with returning data */
`timescale 1ns/1ps
`default_nettype none

module psram_read_engine import psram_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire psram_req_t req_data,
	output logic ack,
	output psram_wave_t wave
);

`include "psram_consts.svh"

	logic [0:`PSRAM_RD_STEPS-1] rd_sr;
	logic start;
	logic [31:0] rd_addr;
	psram_pad_out_t pad;

	// Only read requests start this chain
	assign start = req && !ack && !(|rd_sr) && (req_data.cmd == CMD_READ);

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_sr <= '0;
			ack <= 1'b0;
		end else begin
			rd_sr <= {start, rd_sr[0:`PSRAM_RD_STEPS-2]};
			// Ack the cycle after the last step, release once req drops
			if (rd_sr[`PSRAM_RD_STEPS-1])
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
		end
	end

	assign rd_addr = {7'h00, req_data.addr[24:3], 3'b000};

	////////////////////////////////////////////////////////////
	// Step table
	////////////////////////////////////////////////////////////

	always_comb begin
		pad = '0;
		if (rd_sr[0])
			pad |= psram_step(1'b1, `PSRAM_CMD_RDMEM, `PSRAM_CMD_RDMEM);
		if (rd_sr[1])
			pad |= psram_step(1'b1, rd_addr[31:24], rd_addr[23:16]);
		if (rd_sr[2])
			pad |= psram_step(1'b1, rd_addr[15:8], rd_addr[7:0]);
		// Latency and data steps clock with dq released
		for (int s = `PSRAM_LAT_STEP; s < `PSRAM_RD_STEPS - 1; s++)
			if (rd_sr[s])
				pad |= psram_step(1'b0, 8'h00, 8'h00);
		// Last step deselects, all zero
	end

	assign wave = '{pad: pad, le: |rd_sr[`PSRAM_DATA_STEP +: `PSRAM_RD_BEATS]};

endmodule

`default_nettype wire

// File: source/psram_sequencer.sv
/* Runs power-up, reset and config, then serves one transfer at a time.
   Write wins over read when both address channels are valid */
`timescale 1ns/1ps
`default_nettype none

module psram_sequencer import psram_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [24:0] awaddr,
	input wire logic awvalid,
	input wire logic [24:0] araddr,
	input wire logic arvalid,
	output logic awready,
	output logic arready,
	output logic bvalid,
	output logic psram_ready,
	output logic wr_req,
	output psram_req_t wr_req_data,
	input wire logic wr_ack,
	output logic rd_req,
	output psram_req_t rd_req_data,
	input wire logic rd_ack
);

`include "psram_consts.svh"

	localparam int DELAY_W = $clog2(`PSRAM_STARTUP_CYCLES + 1);

	typedef enum logic [2:0] {
		ST_STARTUP,
		ST_RESET,
		ST_RECOVER,
		ST_CONFIG,
		ST_READY,
		ST_WRITE,
		ST_READ,
		ST_DONE
	} seq_state_e;

	seq_state_e state;
	logic [DELAY_W-1:0] delay;
	logic launch_reset;
	logic launch_config;

	////////////////////////////////////////////////////////////
	// Launch conditions
	////////////////////////////////////////////////////////////

	assign launch_reset = (state == ST_STARTUP) && (delay == '0);
	// Recovery done and the reset ack already released
	assign launch_config = (state == ST_RECOVER) && (delay == '0) && !wr_ack;

	// Address handshakes only in ready
	assign awready = (state == ST_READY) && awvalid;
	assign arready = (state == ST_READY) && arvalid && !awvalid;

	////////////////////////////////////////////////////////////
	// Init order and dispatch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_STARTUP;
			delay <= DELAY_W'(`PSRAM_STARTUP_CYCLES);
			wr_req <= 1'b0;
			rd_req <= 1'b0;
			bvalid <= 1'b0;
			psram_ready <= 1'b0;
		end else begin
			bvalid <= 1'b0;
			// Free-running countdown, reloaded for recovery
			if (delay != '0)
				delay <= delay - 1'b1;
			case (state)
				ST_STARTUP: begin
					if (launch_reset) begin
						wr_req <= 1'b1;
						state <= ST_RESET;
					end
				end
				ST_RESET: begin
					if (wr_ack) begin
						wr_req <= 1'b0;
						delay <= DELAY_W'(`PSRAM_RESET_CYCLES);
						state <= ST_RECOVER;
					end
				end
				ST_RECOVER: begin
					if (launch_config) begin
						wr_req <= 1'b1;
						state <= ST_CONFIG;
					end
				end
				ST_CONFIG: begin
					if (wr_ack) begin
						wr_req <= 1'b0;
						psram_ready <= 1'b1;
						state <= ST_DONE;
					end
				end
				ST_READY: begin
					if (awready) begin
						wr_req <= 1'b1;
						state <= ST_WRITE;
					end else if (arready) begin
						rd_req <= 1'b1;
						state <= ST_READ;
					end
				end
				ST_WRITE: begin
					// Write response one cycle after ack
					if (wr_ack) begin
						wr_req <= 1'b0;
						bvalid <= 1'b1;
						state <= ST_DONE;
					end
				end
				ST_READ: begin
					if (rd_ack) begin
						rd_req <= 1'b0;
						state <= ST_DONE;
					end
				end
				// Wait for both acks low before the next request
				ST_DONE: begin
					if (!wr_ack && !rd_ack)
						state <= ST_READY;
				end
				default: state <= ST_STARTUP;
			endcase
		end
	end

	// Request payloads, loaded only at launch
	always_ff @(posedge clk) begin
		if (launch_reset)
			wr_req_data <= '{cmd: CMD_RESET, addr: '0};
		else if (launch_config)
			wr_req_data <= '{cmd: CMD_CONFIG, addr: '0};
		else if (awready)
			wr_req_data <= '{cmd: CMD_WRITE, addr: awaddr};
		if (arready)
			rd_req_data <= '{cmd: CMD_READ, addr: araddr};
	end

	// Request held with a fixed payload until the engine answers
	a_wr_req_hold: assert property (@(posedge clk) disable iff (reset)
		wr_req && !wr_ack |=> wr_req && $stable(wr_req_data));
	a_rd_req_hold: assert property (@(posedge clk) disable iff (reset)
		rd_req && !rd_ack |=> rd_req && $stable(rd_req_data));

endmodule

`default_nettype wire

// File: source/psram_phy.sv
/* Pad outputs are registered here, one wave per cycle. Read data is expected
   PSRAM_RD_DELAY cycles after its wave step, counted at the registered pad input */
`timescale 1ns/1ps
`default_nettype none

module psram_phy import psram_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire psram_wave_t wr_wave,
	input wire psram_wave_t rd_wave,
	input wire psram_pad_in_t pad_in,
	output psram_pad_out_t pad_out,
	output logic [17:0] rdata,
	output logic rvalid
);

`include "psram_consts.svh"

	psram_wave_t wave_or;
	psram_pad_in_t pad_in_q;
	// le delay line, top bit aligned with pad_in_q
	logic [`PSRAM_RD_DELAY-1:0] le_pipe;

	// Idle engines drive zeros, so OR merges them
	assign wave_or = wr_wave | rd_wave;

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			pad_out <= '0;
		else
			pad_out <= wave_or.pad;
	end

	////////////////////////////////////////////////////////////
	// Read capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		pad_in_q <= pad_in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			le_pipe <= '0;
			rvalid <= 1'b0;
		end else begin
			le_pipe <= {le_pipe[`PSRAM_RD_DELAY-2:0], wave_or.le};
			rvalid <= le_pipe[`PSRAM_RD_DELAY-1];
		end
	end

	// Two bytes with their rwds bits per beat
	always_ff @(posedge clk) begin
		if (le_pipe[`PSRAM_RD_DELAY-1])
			rdata <= pad_in_q;
	end

	// Sequencer serializes commands, so chip select never comes from both
	a_single_cs: assert property (@(posedge clk) disable iff (reset)
		!((|wr_wave.pad.cs) && (|rd_wave.pad.cs)));

endmodule

`default_nettype wire

// File: source/psram_ctrl.sv
/* Octal PSRAM controller, 16M x 16, single clk. Write bursts of 8 beats, read bursts
   of 8 bytes; wvalid must be high during wready and read data has no back-pressure */
`timescale 1ns/1ps
`default_nettype none

module psram_ctrl import psram_pkg::*; (
	input wire logic clk,
	input wire logic reset,

	// Write address and data
	input wire logic [24:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [15:0] wdata,
	input wire logic wvalid,
	output logic wready,
	output logic bvalid,

	// Read address and data
	input wire logic [24:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [17:0] rdata,
	output logic rvalid,

	output logic psram_ready,

	// Toward the 4x serializer
	output psram_pad_out_t pad_out,
	input wire psram_pad_in_t pad_in
);

	// Command launch channels
	logic wr_req;
	logic wr_ack;
	psram_req_t wr_req_data;
	logic rd_req;
	logic rd_ack;
	psram_req_t rd_req_data;

	// Per-engine waves, merged in the phy
	psram_wave_t wr_wave;
	psram_wave_t rd_wave;

	psram_sequencer psram_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.awready     (awready),
		.arready     (arready),
		.bvalid      (bvalid),
		.psram_ready (psram_ready),
		.wr_req      (wr_req),
		.wr_req_data (wr_req_data),
		.wr_ack      (wr_ack),
		.rd_req      (rd_req),
		.rd_req_data (rd_req_data),
		.rd_ack      (rd_ack)
	);

	psram_write_engine psram_write_engine_i (
		.clk      (clk),
		.reset    (reset),
		.req      (wr_req),
		.req_data (wr_req_data),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.ack      (wr_ack),
		.wready   (wready),
		.wave     (wr_wave)
	);

	psram_read_engine psram_read_engine_i (
		.clk      (clk),
		.reset    (reset),
		.req      (rd_req),
		.req_data (rd_req_data),
		.ack      (rd_ack),
		.wave     (rd_wave)
	);

	psram_phy psram_phy_i (
		.clk     (clk),
		.reset   (reset),
		.wr_wave (wr_wave),
		.rd_wave (rd_wave),
		.pad_in  (pad_in),
		.pad_out (pad_out),
		.rdata   (rdata),
		.rvalid  (rvalid)
	);

endmodule

`default_nettype wire

// File: verif/psram_mem_model.sv
/* Behavioral PSRAM behind the 4x serializer, one command per cs frame.
   Unwritten bytes read as the low address byte XOR 8'h5A, rwds is always 0 */
`timescale 1ns/1ps
`default_nettype none

module psram_mem_model import psram_pkg::*; (
	input wire logic clk,
	input wire psram_pad_out_t pad_out,
	output psram_pad_in_t pad_in
);

`include "psram_consts.svh"

	// Sparse byte store
	logic [7:0] mem [logic [31:0]];
	// Step count inside the current cs frame
	int step = 0;
	logic [7:0] cmd = '0;
	logic [31:0] addr = '0;
	// Command history and register contents, read by the testbench
	logic [7:0] cmd_log [0:31];
	logic [4:0] cmd_count = '0;
	logic [15:0] cfg_data = '0;
	logic [31:0] last_wr_addr = '0;

	function automatic logic [7:0] stored_byte(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return a[7:0] ^ 8'h5A;
	endfunction

	initial pad_in = '0;

	always @(posedge clk) begin : decode
		logic [31:0] ofs;
		int beat;
		pad_in <= '0;
		if (pad_out.cs == 4'b0000) begin
			step <= 0;
		end else begin
			step <= step + 1;
			// Beat index counted from the first data step
			beat = step - `PSRAM_DATA_STEP;
			ofs = addr + 32'(2 * beat);
			if (step == 0) begin
				cmd <= pad_out.dq[1];
				cmd_log[cmd_count] <= pad_out.dq[1];
				cmd_count <= cmd_count + 5'd1;
			end else if (step == 1) begin
				addr[31:16] <= {pad_out.dq[1], pad_out.dq[2]};
			end else if (step == 2) begin
				addr[15:0] <= {pad_out.dq[1], pad_out.dq[2]};
			end else if (cmd == `PSRAM_CMD_WRREG && step == 3) begin
				cfg_data <= {pad_out.dq[1], pad_out.dq[2]};
			end else if (cmd == `PSRAM_CMD_WRMEM && beat >= 0 && beat < `PSRAM_WR_BEATS) begin
				// High byte of the beat lands first
				mem[ofs] = pad_out.dq[1];
				mem[ofs + 32'd1] = pad_out.dq[2];
				if (beat == 0)
					last_wr_addr <= addr;
			end else if (cmd == `PSRAM_CMD_RDMEM && beat >= 0 && beat < `PSRAM_RD_BEATS &&
				pad_out.sclk != 4'b0000) begin
				// Answer one cycle after the clocked data step
				pad_in <= '{rwds0: 1'b0, data0: stored_byte(ofs),
					rwds1: 1'b0, data1: stored_byte(ofs + 32'd1)};
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/psram_ctrl_tb.sv
/* Runs init, two writes and three reads with random addresses and data from a
   fixed seed. The memory model answers in place of the serializer and the device */
`timescale 1ns/1ps
`default_nettype none

module psram_ctrl_tb import psram_pkg::*; ();

`include "psram_consts.svh"

	localparam int TRANSFERS = 5;
	localparam int WATCHDOG_NS = (`PSRAM_STARTUP_CYCLES + 400 * TRANSFERS) * 20;

	logic clk = 1'b0;
	logic reset;
	logic [24:0] awaddr;
	logic awvalid;
	logic awready;
	logic [15:0] wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic [24:0] araddr;
	logic arvalid;
	logic arready;
	logic [17:0] rdata;
	logic rvalid;
	logic psram_ready;
	psram_pad_out_t pad_out;
	psram_pad_in_t pad_in;

	int seed = 32'hbe3a;
	logic [31:0] rnd;
	logic [24:0] addr_a;
	logic [24:0] addr_b;
	// Expected memory contents after each write
	logic [7:0] ref_mem [logic [31:0]];
	// Open transfer tracking
	logic write_open;
	logic read_open;
	logic [3:0] wr_seen;
	logic [2:0] rd_seen;

	psram_ctrl psram_ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wvalid      (wvalid),
		.wready      (wready),
		.bvalid      (bvalid),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rvalid      (rvalid),
		.psram_ready (psram_ready),
		.pad_out     (pad_out),
		.pad_in      (pad_in)
	);

	psram_mem_model mem_model_i (
		.clk     (clk),
		.pad_out (pad_out),
		.pad_in  (pad_in)
	);

	always #10 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else fail_run($sformatf("error at %0d ns: %s is %h, expected %h",
			$time, name, got, expected));
	endtask

	function automatic logic [7:0] expected_byte(input logic [31:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a[7:0] ^ 8'h5A;
	endfunction

	////////////////////////////////////////////////////////////
	// Transfers
	////////////////////////////////////////////////////////////

	task automatic write_burst(input logic [24:0] addr);
		logic [15:0] beats [0:7];
		logic [31:0] base;
		int n;
		// Burst starts on a 16 byte boundary
		base = {7'h00, addr} & ~32'h0000_000f;
		for (n = 0; n < 8; n++) begin
			rnd = $random(seed);
			beats[n] = rnd[15:0];
		end
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= beats[0];
		wvalid <= 1'b1;
		@(posedge clk);
		while (!awready)
			@(posedge clk);
		awvalid <= 1'b0;
		n = 0;
		// Next beat after each accepted one
		while (!bvalid) begin
			@(posedge clk);
			if (wready) begin
				n++;
				if (n < 8)
					wdata <= beats[n];
				else
					wvalid <= 1'b0;
			end
		end
		check_value("wready beats", 32'(n), 32'd8);
		check_value("model command", 32'(mem_model_i.cmd_log[mem_model_i.cmd_count - 5'd1]),
			32'(`PSRAM_CMD_WRMEM));
		check_value("model write address", mem_model_i.last_wr_addr, base);
		for (n = 0; n < 8; n++) begin
			ref_mem[base + 32'(2 * n)] = beats[n][15:8];
			ref_mem[base + 32'(2 * n + 1)] = beats[n][7:0];
		end
		for (n = 0; n < 16; n++)
			check_value("model byte", 32'(mem_model_i.stored_byte(base + 32'(n))),
				32'(ref_mem[base + 32'(n)]));
	endtask

	task automatic read_burst(input logic [24:0] addr);
		logic [31:0] base;
		logic [17:0] expected;
		int n;
		// Burst starts on an 8 byte boundary
		base = {7'h00, addr} & ~32'h0000_0007;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		n = 0;
		// Beats arrive in byte address order, rwds zero
		while (n < `PSRAM_RD_BEATS) begin
			@(posedge clk);
			if (rvalid) begin
				expected = {1'b0, expected_byte(base + 32'(2 * n)),
					1'b0, expected_byte(base + 32'(2 * n + 1))};
				check_value("rdata", 32'(rdata), 32'(expected));
				n++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Protocol monitors and assertions
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (reset) begin
			write_open <= 1'b0;
			read_open <= 1'b0;
			wr_seen <= '0;
			rd_seen <= '0;
		end else begin
			if (awready) begin
				write_open <= 1'b1;
				wr_seen <= '0;
			end else if (bvalid) begin
				write_open <= 1'b0;
			end else if (wready) begin
				wr_seen <= wr_seen + 4'd1;
			end
			// Read closes on its last beat
			if (arready) begin
				read_open <= 1'b1;
				rd_seen <= '0;
			end else if (rvalid) begin
				rd_seen <= rd_seen + 3'd1;
				if (rd_seen == 3'(`PSRAM_RD_BEATS - 1))
					read_open <= 1'b0;
			end
		end
	end

	a_no_early_handshake: assert property (@(posedge clk) disable iff (reset)
		(awready || arready) |-> psram_ready)
		else fail_run("address handshake before psram_ready");
	a_ready_held: assert property (@(posedge clk) disable iff (reset)
		psram_ready |=> psram_ready)
		else fail_run("psram_ready dropped without reset");
	a_ready_after_config: assert property (@(posedge clk) disable iff (reset)
		psram_ready |-> (mem_model_i.cmd_count >= 5'd4 &&
		mem_model_i.cfg_data == `PSRAM_CR0_VALUE))
		else fail_run("psram_ready high before the config register was written");
	a_write_first: assert property (@(posedge clk) disable iff (reset)
		(awvalid && arvalid) |-> !arready)
		else fail_run("read accepted while a write address was waiting");
	a_wready_in_write: assert property (@(posedge clk) disable iff (reset)
		wready |-> (write_open && wr_seen < 4'(`PSRAM_WR_BEATS)))
		else fail_run("wready outside a write or more than 8 beats");
	a_bvalid_once: assert property (@(posedge clk) disable iff (reset)
		bvalid |-> (write_open && wr_seen == 4'(`PSRAM_WR_BEATS)))
		else fail_run("bvalid without a complete write");
	a_rvalid_in_read: assert property (@(posedge clk) disable iff (reset)
		rvalid |-> read_open)
		else fail_run("rvalid outside a read or more than 4 beats");

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout, the tests did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		rnd = $random(seed);
		addr_a = rnd[24:0];
		// Write requested during init, served only once ready
		fork
			write_burst(addr_a);
			begin
				@(posedge clk);
				while (!psram_ready)
					@(posedge clk);
				check_value("command 0", 32'(mem_model_i.cmd_log[0]), 32'(`PSRAM_CMD_RSTEN));
				check_value("command 1", 32'(mem_model_i.cmd_log[1]), 32'(`PSRAM_CMD_RST));
				check_value("command 2", 32'(mem_model_i.cmd_log[2]), 32'(`PSRAM_CMD_WREN));
				check_value("command 3", 32'(mem_model_i.cmd_log[3]), 32'(`PSRAM_CMD_WRREG));
				check_value("config data", 32'(mem_model_i.cfg_data), 32'(`PSRAM_CR0_VALUE));
			end
		join
		read_burst(addr_a);
		// Unwritten address gives the fill pattern
		rnd = $random(seed);
		read_burst(rnd[24:0]);
		// Both address channels at once
		rnd = $random(seed);
		addr_b = rnd[24:0];
		fork
			write_burst(addr_b);
			read_burst(addr_b);
		join
		// Quiet window for stray responses
		repeat (20) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/psram_pkg.sv
engine/psram_write_engine.sv
engine/psram_read_engine.sv
source/psram_sequencer.sv
source/psram_phy.sv
source/psram_ctrl.sv
verif/psram_mem_model.sv
verif/psram_ctrl_tb.sv

// File: Bender.yml
package:
  name: psram_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/psram_pkg.sv
      - engine/psram_write_engine.sv
      - engine/psram_read_engine.sv
      - source/psram_sequencer.sv
      - source/psram_phy.sv
      - source/psram_ctrl.sv
      - target: test
        files:
          - verif/psram_mem_model.sv
          - verif/psram_ctrl_tb.sv
